/* Makefile */
TOP = tb_fetch_frontend
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f verilog.f

# an aborted run (failed assertion) is also recorded as a failure in the log
run: compile
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || echo "SOME TESTS FAILED" >> $(LOG)
	cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

/* sim/fetch_frontend_props.sv */
`timescale 1ns/1ps

module fetch_frontend_props (
    input logic                       clk_i,
    input logic                       rst_ni,
    input logic                       has_room_i,
    input logic                       mispredict_i,
    input logic                       imem_req_i,
    input logic                       fetch_valid_i,
    input logic                       fetch_ready_i,
    input logic [fetch_pkg::XLEN-1:0] fetch_pc_i,
    input logic [fetch_pkg::XLEN-1:0] fetch_instr_i,
    input logic                       fetch_pred_taken_i,
    input logic [fetch_pkg::XLEN-1:0] fetch_pred_target_i
);

    // ----------------------------------------
    // output handshake
    // ----------------------------------------
    // a stalled entry stays put unless a flush removes it
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (fetch_valid_i && !fetch_ready_i && !mispredict_i) |=>
        (fetch_valid_i && $stable(fetch_pc_i) && $stable(fetch_instr_i)
         && $stable(fetch_pred_taken_i) && $stable(fetch_pred_target_i)))
    else $error("fetch entry changed while stalled");

    // ----------------------------------------
    // reset and requests
    // ----------------------------------------
    assert property (@(posedge clk_i) $rose(rst_ni) |-> (!fetch_valid_i && !imem_req_i))
    else $error("output or request active right after reset");

    assert property (@(posedge clk_i) disable iff (!rst_ni) imem_req_i |-> has_room_i)
    else $error("memory request issued without queue room");

endmodule

bind fetch_frontend fetch_frontend_props i_props (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .has_room_i          (has_room),
    .mispredict_i        (mispredict),
    .imem_req_i          (imem_req_o),
    .fetch_valid_i       (fetch_valid_o),
    .fetch_ready_i       (fetch_ready_i),
    .fetch_pc_i          (fetch_pc_o),
    .fetch_instr_i       (fetch_instr_o),
    .fetch_pred_taken_i  (fetch_pred_taken_o),
    .fetch_pred_target_i (fetch_pred_target_o)
);

/* sim/tb_fetch_frontend.sv */
`timescale 1ns/1ps

module tb_fetch_frontend;

    // program image, the first words hold straight-line code only
    localparam int unsigned MEM_WORDS    = 256;
    localparam int unsigned FILLER_WORDS = 32;
    localparam logic [31:0] BOOT_ADDR    = 32'h0000_0010;
    // forward branch right after the filler region
    localparam logic [31:0] TRAIN_PC     = 32'h0000_0080;
    localparam int unsigned WAIT_LIMIT   = 64;

    logic                       clk_i = 1'b0;
    logic                       rst_ni;
    logic [fetch_pkg::XLEN-1:0] boot_addr_i;
    logic                       imem_req_o;
    logic [fetch_pkg::XLEN-1:0] imem_addr_o;
    logic                       imem_valid_i;
    logic [fetch_pkg::XLEN-1:0] imem_data_i;
    logic                       resolve_valid_i;
    logic [fetch_pkg::XLEN-1:0] resolve_pc_i;
    logic                       resolve_is_branch_i;
    logic                       resolve_taken_i;
    logic                       resolve_mispredict_i;
    logic [fetch_pkg::XLEN-1:0] resolve_target_i;
    logic                       fetch_valid_o;
    logic [fetch_pkg::XLEN-1:0] fetch_pc_o;
    logic [fetch_pkg::XLEN-1:0] fetch_instr_o;
    logic                       fetch_pred_taken_o;
    logic [fetch_pkg::XLEN-1:0] fetch_pred_target_o;
    logic                       fetch_ready_i;

    logic [fetch_pkg::XLEN-1:0] mem [MEM_WORDS];
    logic [31:0]                rng_state = 32'd23;
    // mirror of the bht, trained only by resolutions sent from here
    logic [1:0]                 m_cnt [16];
    logic [15:0]                m_valid = '0;
    logic [fetch_pkg::XLEN-1:0] exp_pc;
    // last accepted entry
    logic                       got_entry;
    logic [fetch_pkg::XLEN-1:0] ent_pc;
    logic [fetch_pkg::XLEN-1:0] ent_instr;
    logic                       ent_taken;
    logic [fetch_pkg::XLEN-1:0] ent_target;
    // request seen in the previous cycle
    logic                       req_q = 1'b0;
    logic [fetch_pkg::XLEN-1:0] addr_q = '0;
    int                         test_errors = 0;
    int                         tests_run = 0;
    int                         tests_failed = 0;
    int                         seen_jal;
    int                         seen_branch;

    fetch_frontend uut (.*);

    always #4 clk_i = ~clk_i;

    // memory answers every request one cycle later
    always @(negedge clk_i) begin
        imem_valid_i = req_q;
        imem_data_i  = req_q ? mem[addr_q[9:2]] : '0;
        req_q        = imem_req_o;
        addr_q       = imem_addr_o;
    end

    // ----------------------------------------
    // random numbers and encodings
    // ----------------------------------------
    function automatic logic [31:0] xorshift();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic [31:0] branch_word(input logic [12:0] off, input logic [31:0] r);
        return {off[12], off[10:5], r[24:20], r[19:15], r[14:12], off[4:1], off[11],
                fetch_pkg::OPC_BRANCH};
    endfunction

    function automatic logic [31:0] jal_word(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, fetch_pkg::OPC_JAL};
    endfunction

    function automatic logic [31:0] b_imm(input logic [31:0] w);
        return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    endfunction

    function automatic logic [31:0] j_imm(input logic [31:0] w);
        return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    endfunction

    task automatic fill_memory();
        logic [31:0] r;
        logic [31:0] w;
        logic [12:0] boff;
        logic [20:0] joff;
        for (int i = 0; i < MEM_WORDS; i++) begin
            r    = xorshift();
            w    = xorshift();
            boff = 13'((32'(r[3:0]) % 12 + 1) * 4);
            joff = 21'((32'(r[8:4]) + 1) * 4);
            // mostly alu words, the rest branches both ways and jumps
            if (i < FILLER_WORDS || r[31:28] < 4'd10) begin
                mem[i] = {w[31:7], 7'b0010011};
            end else if (r[31:28] < 4'd12) begin
                mem[i] = branch_word(boff, w);
            end else if (r[31:28] < 4'd14) begin
                mem[i] = branch_word(13'd0 - boff, w);
            end else begin
                mem[i] = jal_word(r[27] ? 21'd0 - joff : joff, w[11:7]);
            end
        end
        // fixed forward branch and jal where the random region starts
        mem[32] = branch_word(13'd12, xorshift());
        mem[33] = jal_word(21'd24, 5'd1);
    endtask

    // ----------------------------------------
    // reference model
    // ----------------------------------------
    task automatic predict(input logic [31:0] pc, input logic [31:0] w,
                           output logic taken, output logic [31:0] target);
        logic [31:0] imm;
        logic [3:0]  idx;
        idx   = pc[5:2];
        taken = 1'b0;
        imm   = b_imm(w);
        if (w[6:0] == fetch_pkg::OPC_JAL) begin
            imm   = j_imm(w);
            taken = 1'b1;
        end else if (w[6:0] == fetch_pkg::OPC_BRANCH) begin
            // trained counter wins, else backward means taken
            taken = m_valid[idx] ? m_cnt[idx][1] : imm[31];
        end
        target = taken ? pc + imm : pc + 32'd4;
    endtask

    task automatic check_entry(input string name);
        logic [fetch_pkg::XLEN-1:0] word;
        logic                       taken;
        logic [fetch_pkg::XLEN-1:0] target;
        word = mem[exp_pc[9:2]];
        predict(exp_pc, word, taken, target);
        // control words that really came out of the frontend
        if (ent_instr[6:0] == fetch_pkg::OPC_JAL) begin
            seen_jal++;
        end
        if (ent_instr[6:0] == fetch_pkg::OPC_BRANCH) begin
            seen_branch++;
        end
        if (ent_pc !== exp_pc) begin
            $display("ERROR %s pc: expected %h, actual %h", name, exp_pc, ent_pc);
            test_errors++;
        end
        if (ent_instr !== word) begin
            $display("ERROR %s instr: expected %h, actual %h", name, word, ent_instr);
            test_errors++;
        end
        if (ent_taken !== taken) begin
            $display("ERROR %s pred_taken: expected %b, actual %b", name, taken, ent_taken);
            test_errors++;
        end
        if (ent_target !== target) begin
            $display("ERROR %s pred_target: expected %h, actual %h", name, target, ent_target);
            test_errors++;
        end
        // next entry on the path follows the prediction
        exp_pc = target;
    endtask

    // ----------------------------------------
    // stimulus helpers
    // ----------------------------------------
    // one cycle, entry counts as taken if valid and ready meet at the next rise
    task automatic next_cycle(input logic rdy);
        @(negedge clk_i);
        resolve_valid_i      = 1'b0;
        resolve_is_branch_i  = 1'b0;
        resolve_mispredict_i = 1'b0;
        fetch_ready_i        = rdy;
        got_entry            = fetch_valid_o & rdy;
        if (got_entry) begin
            ent_pc     = fetch_pc_o;
            ent_instr  = fetch_instr_o;
            ent_taken  = fetch_pred_taken_o;
            ent_target = fetch_pred_target_o;
        end
    endtask

    task automatic wait_entry(input string name, input logic rand_ready, output logic ok);
        logic [31:0] r;
        int          n;
        n         = 0;
        got_entry = 1'b0;
        while (!got_entry && n < WAIT_LIMIT) begin
            r = xorshift();
            next_cycle(rand_ready ? r[0] : 1'b1);
            n++;
        end
        ok = got_entry;
        if (!ok) begin
            $display("%s: timed out waiting for an accepted fetch entry", name);
            test_errors++;
        end
    endtask

    task automatic accept_run(input string name, input int count, input logic rand_ready);
        logic ok;
        for (int k = 0; k < count; k++) begin
            wait_entry(name, rand_ready, ok);
            if (!ok) begin
                break;
            end
            check_entry(name);
        end
    endtask

    // one resolve strobe with the output stalled, model follows along
    task automatic resolve(input logic [31:0] pc, input logic is_branch, input logic taken,
                           input logic mispredict, input logic [31:0] target);
        logic [3:0] idx;
        @(negedge clk_i);
        fetch_ready_i        = 1'b0;
        resolve_valid_i      = 1'b1;
        resolve_pc_i         = pc;
        resolve_is_branch_i  = is_branch;
        resolve_taken_i      = taken;
        resolve_mispredict_i = mispredict;
        resolve_target_i     = target;
        idx                  = pc[5:2];
        if (is_branch) begin
            if (!m_valid[idx]) begin
                m_cnt[idx] = taken ? 2'd2 : 2'd1;
            end else if (taken) begin
                if (m_cnt[idx] != 2'd3) begin
                    m_cnt[idx] = m_cnt[idx] + 2'd1;
                end
            end else if (m_cnt[idx] != 2'd0) begin
                m_cnt[idx] = m_cnt[idx] - 2'd1;
            end
            m_valid[idx] = 1'b1;
        end
        if (mispredict) begin
            exp_pc = target;
        end
    endtask

    task automatic finish_test(input string name);
        $display("%s: %s, %0d errors", name, (test_errors == 0) ? "passed" : "failed",
                 test_errors);
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        test_errors = 0;
    endtask

    // ----------------------------------------
    // test sequence
    // ----------------------------------------
    initial begin
        logic        ok;
        logic [31:0] r;
        logic [31:0] tgt;
        int          n_acc;
        rst_ni               = 1'b1;
        boot_addr_i          = BOOT_ADDR;
        imem_valid_i         = 1'b0;
        imem_data_i          = '0;
        resolve_valid_i      = 1'b0;
        resolve_pc_i         = '0;
        resolve_is_branch_i  = 1'b0;
        resolve_taken_i      = 1'b0;
        resolve_mispredict_i = 1'b0;
        resolve_target_i     = '0;
        fetch_ready_i        = 1'b0;
        fill_memory();
        exp_pc = BOOT_ADDR;
        #2 rst_ni = 1'b0;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;

        // reset_boot
        next_cycle(1'b0);
        if (fetch_valid_o !== 1'b0) begin
            $display("ERROR reset_boot fetch_valid_o: expected 0, actual %b", fetch_valid_o);
            test_errors++;
        end
        wait_entry("reset_boot", 1'b0, ok);
        if (ok) begin
            if (ent_pc !== BOOT_ADDR) begin
                $display("ERROR reset_boot pc: expected %h, actual %h", BOOT_ADDR, ent_pc);
                test_errors++;
            end
            check_entry("reset_boot");
        end
        finish_test("reset_boot");

        // stays inside the filler words
        accept_run("sequential_flow", 20, 1'b0);
        finish_test("sequential_flow");

        seen_jal    = 0;
        seen_branch = 0;
        accept_run("static_and_jal_prediction", 40, 1'b0);
        if (seen_jal == 0 || seen_branch == 0) begin
            $display("static_and_jal_prediction: no jal or no branch reached the output");
            test_errors++;
        end
        finish_test("static_and_jal_prediction");

        // two taken outcomes, then refetch the branch
        resolve(TRAIN_PC, 1'b1, 1'b1, 1'b0, '0);
        resolve(TRAIN_PC, 1'b1, 1'b1, 1'b0, '0);
        resolve(TRAIN_PC, 1'b0, 1'b0, 1'b1, TRAIN_PC);
        wait_entry("bht_training", 1'b0, ok);
        if (ok) begin
            if (ent_pc !== TRAIN_PC || ent_taken !== 1'b1) begin
                $display("ERROR bht_training pc/taken: expected %h/1, actual %h/%b",
                         TRAIN_PC, ent_pc, ent_taken);
                test_errors++;
            end
            check_entry("bht_training");
        end
        accept_run("bht_training", 10, 1'b0);
        finish_test("bht_training");

        // leave old entries queued, then jump away
        accept_run("mispredict_redirect", 5, 1'b1);
        r   = xorshift();
        tgt = r & 32'h0000_0FFC;
        resolve(32'h0, 1'b0, 1'b0, 1'b1, tgt);
        wait_entry("mispredict_redirect", 1'b1, ok);
        if (ok) begin
            if (ent_pc !== tgt) begin
                $display("ERROR mispredict_redirect pc: expected %h, actual %h", tgt, ent_pc);
                test_errors++;
            end
            check_entry("mispredict_redirect");
        end
        accept_run("mispredict_redirect", 10, 1'b1);
        finish_test("mispredict_redirect");

        n_acc = 0;
        for (int c = 0; c < 300; c++) begin
            r = xorshift();
            next_cycle(r[0]);
            if (got_entry) begin
                check_entry("back_pressure");
                n_acc++;
            end
        end
        if (n_acc == 0) begin
            $display("back_pressure: no entry was accepted in 300 cycles");
            test_errors++;
        end
        finish_test("back_pressure");

        $display("tests run %0d, passed %0d, failed %0d", tests_run,
                 tests_run - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* source/bht.sv */
`timescale 1ns/1ps

module bht (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic [fetch_pkg::XLEN-1:0] rd_pc_i,
    input  logic                       wr_valid_i,
    input  logic [fetch_pkg::XLEN-1:0] wr_pc_i,
    input  logic                       wr_taken_i,
    output logic                       rd_valid_o,
    output logic                       rd_taken_o
);

    logic [fetch_pkg::BHT_ENTRIES-1:0] valid_q;
    logic [1:0]                        cnt_q [fetch_pkg::BHT_ENTRIES];
    logic [fetch_pkg::BHT_IDX_W-1:0]   rd_idx;
    logic [fetch_pkg::BHT_IDX_W-1:0]   wr_idx;

    // word aligned pcs, skip the two low bits
    assign rd_idx = rd_pc_i[fetch_pkg::BHT_IDX_W+1:2];
    assign wr_idx = wr_pc_i[fetch_pkg::BHT_IDX_W+1:2];

    // combinational lookup, msb of the counter is the direction
    assign rd_valid_o = valid_q[rd_idx];
    assign rd_taken_o = cnt_q[rd_idx][1];

    // all entries start untrained
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (wr_valid_i) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // ----------------------------------------
    // counter update
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (wr_valid_i) begin
            if (!valid_q[wr_idx]) begin
                // first outcome seeds a weak state
                cnt_q[wr_idx] <= wr_taken_i ? 2'd2 : 2'd1;
            end else if (wr_taken_i) begin
                if (cnt_q[wr_idx] != 2'd3) begin
                    cnt_q[wr_idx] <= cnt_q[wr_idx] + 2'd1;
                end
            end else if (cnt_q[wr_idx] != 2'd0) begin
                cnt_q[wr_idx] <= cnt_q[wr_idx] - 2'd1;
            end
        end
    end

endmodule

/* source/branch_predecode.sv */
`timescale 1ns/1ps

module branch_predecode (
    input  logic [fetch_pkg::XLEN-1:0] instr_i,
    input  logic [fetch_pkg::XLEN-1:0] pc_i,
    input  logic                       bht_valid_i,
    input  logic                       bht_taken_i,
    output logic                       is_branch_o,
    output logic                       pred_taken_o,
    output logic [fetch_pkg::XLEN-1:0] pred_target_o
);

    fetch_pkg::instr_u          word;
    logic                       is_jal;
    logic [fetch_pkg::XLEN-1:0] imm_b;
    logic [fetch_pkg::XLEN-1:0] imm_j;
    logic [fetch_pkg::XLEN-1:0] imm_sel;

    assign word = instr_i;

    // ----------------------------------------
    // format decode
    // ----------------------------------------
    // opcode sits at the same place in both views
    assign is_branch_o = (word.b.opcode == fetch_pkg::OPC_BRANCH);
    assign is_jal      = (word.j.opcode == fetch_pkg::OPC_JAL);

    // sign extended b immediate, bit 0 always zero
    assign imm_b = {{(fetch_pkg::XLEN-12){word.b.imm12}}, word.b.imm11,
                    word.b.imm10_5, word.b.imm4_1, 1'b0};

    // sign extended j immediate
    assign imm_j = {{(fetch_pkg::XLEN-20){word.j.imm20}}, word.j.imm19_12,
                    word.j.imm11, word.j.imm10_1, 1'b0};

    assign imm_sel = is_jal ? imm_j : imm_b;

    // ----------------------------------------
    // prediction
    // ----------------------------------------
    always_comb begin
        pred_taken_o = 1'b0;
        if (is_jal) begin
            // jal always leaves the sequential path
            pred_taken_o = 1'b1;
        end else if (is_branch_o) begin
            if (bht_valid_i) begin
                pred_taken_o = bht_taken_i;
            end else begin
                // untrained, backward branches are taken
                pred_taken_o = imm_b[fetch_pkg::XLEN-1];
            end
        end
    end

    // not taken falls through to the next word
    assign pred_target_o = pred_taken_o ? (pc_i + imm_sel) : (pc_i + fetch_pkg::INSTR_BYTES);

endmodule

/* source/fetch_frontend.sv */
`timescale 1ns/1ps

module fetch_frontend (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic [fetch_pkg::XLEN-1:0] boot_addr_i,
    // instruction memory
    output logic                       imem_req_o,
    output logic [fetch_pkg::XLEN-1:0] imem_addr_o,
    input  logic                       imem_valid_i,
    input  logic [fetch_pkg::XLEN-1:0] imem_data_i,
    // branch resolution from the back-end
    input  logic                       resolve_valid_i,
    input  logic [fetch_pkg::XLEN-1:0] resolve_pc_i,
    input  logic                       resolve_is_branch_i,
    input  logic                       resolve_taken_i,
    input  logic                       resolve_mispredict_i,
    input  logic [fetch_pkg::XLEN-1:0] resolve_target_i,
    // fetch entries towards decode
    output logic                       fetch_valid_o,
    output logic [fetch_pkg::XLEN-1:0] fetch_pc_o,
    output logic [fetch_pkg::XLEN-1:0] fetch_instr_o,
    output logic                       fetch_pred_taken_o,
    output logic [fetch_pkg::XLEN-1:0] fetch_pred_target_o,
    input  logic                       fetch_ready_i
);

    logic                       mispredict;
    logic                       bht_we;
    logic                       has_room;
    logic                       s2_valid;
    logic [fetch_pkg::XLEN-1:0] s2_pc;
    logic                       bht_valid;
    logic                       bht_taken;
    logic                       pred_taken;
    logic [fetch_pkg::XLEN-1:0] pred_target;

    // ----------------------------------------
    // back-end strobes
    // ----------------------------------------
    assign mispredict = resolve_valid_i & resolve_mispredict_i;
    // only conditional branches train the table
    assign bht_we     = resolve_valid_i & resolve_is_branch_i;

    pc_gen i_pc_gen (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .boot_addr_i         (boot_addr_i),
        .has_room_i          (has_room),
        .pred_taken_i        (pred_taken),
        .pred_target_i       (pred_target),
        .mispredict_i        (mispredict),
        .mispredict_target_i (resolve_target_i),
        .imem_valid_i        (imem_valid_i),
        .imem_req_o          (imem_req_o),
        .imem_addr_o         (imem_addr_o),
        .s2_valid_o          (s2_valid),
        .s2_pc_o             (s2_pc)
    );

    // lookup happens on the address of the returning word
    bht i_bht (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .rd_pc_i    (s2_pc),
        .wr_valid_i (bht_we),
        .wr_pc_i    (resolve_pc_i),
        .wr_taken_i (resolve_taken_i),
        .rd_valid_o (bht_valid),
        .rd_taken_o (bht_taken)
    );

    // prediction and target for the returning word
    branch_predecode i_branch_predecode (
        .instr_i       (imem_data_i),
        .pc_i          (s2_pc),
        .bht_valid_i   (bht_valid),
        .bht_taken_i   (bht_taken),
        .is_branch_o   (),
        .pred_taken_o  (pred_taken),
        .pred_target_o (pred_target)
    );

    // ----------------------------------------
    // fetch queue
    // ----------------------------------------
    // every live response is pushed, a mispredict empties the queue
    fetch_queue i_fetch_queue (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .flush_i       (mispredict),
        .push_i        (s2_valid),
        .pc_i          (s2_pc),
        .instr_i       (imem_data_i),
        .pred_taken_i  (pred_taken),
        .pred_target_i (pred_target),
        .ready_i       (fetch_ready_i),
        .has_room_o    (has_room),
        .valid_o       (fetch_valid_o),
        .pc_o          (fetch_pc_o),
        .instr_o       (fetch_instr_o),
        .pred_taken_o  (fetch_pred_taken_o),
        .pred_target_o (fetch_pred_target_o)
    );

endmodule

/* source/fetch_pkg.sv */
package fetch_pkg;

    // ----------------------------------------
    // widths and opcodes
    // ----------------------------------------
    localparam int unsigned XLEN = 32;

    // conditional branches and jal, the only control flow seen here
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // byte distance between two sequential instructions
    localparam logic [XLEN-1:0] INSTR_BYTES = 4;

    // ----------------------------------------
    // predictor and queue sizes
    // ----------------------------------------
    // bht is indexed by pc bits 5..2
    localparam int unsigned BHT_ENTRIES = 16;
    localparam int unsigned BHT_IDX_W   = 4;

    localparam int unsigned QUEUE_DEPTH = 4;
    localparam int unsigned QUEUE_CNT_W = 3;
    // highest occupancy that still leaves two free slots
    localparam logic [QUEUE_CNT_W-1:0] QUEUE_ROOM_LVL = QUEUE_CNT_W'(QUEUE_DEPTH - 2);

    // ----------------------------------------
    // instruction formats
    // ----------------------------------------
    // b-type, immediate scattered over bits 31, 30..25, 11..8, 7
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } btype_t;

    // j-type, immediate scattered over bits 31, 30..21, 20, 19..12
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } jtype_t;

    // one fetched word, looked at as branch or as jump
    typedef union packed {
        btype_t b;
        jtype_t j;
    } instr_u;

endpackage

/* source/fetch_queue.sv */
`timescale 1ns/1ps

module fetch_queue (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       flush_i,
    input  logic                       push_i,
    input  logic [fetch_pkg::XLEN-1:0] pc_i,
    input  logic [fetch_pkg::XLEN-1:0] instr_i,
    input  logic                       pred_taken_i,
    input  logic [fetch_pkg::XLEN-1:0] pred_target_i,
    input  logic                       ready_i,
    output logic                       has_room_o,
    output logic                       valid_o,
    output logic [fetch_pkg::XLEN-1:0] pc_o,
    output logic [fetch_pkg::XLEN-1:0] instr_o,
    output logic                       pred_taken_o,
    output logic [fetch_pkg::XLEN-1:0] pred_target_o
);

    // entry storage
    logic [fetch_pkg::XLEN-1:0]        pc_q     [fetch_pkg::QUEUE_DEPTH];
    logic [fetch_pkg::XLEN-1:0]        instr_q  [fetch_pkg::QUEUE_DEPTH];
    logic                              taken_q  [fetch_pkg::QUEUE_DEPTH];
    logic [fetch_pkg::XLEN-1:0]        target_q [fetch_pkg::QUEUE_DEPTH];

    // depth is a power of two, pointers wrap on their own
    logic [fetch_pkg::QUEUE_CNT_W-2:0] wr_ptr_q;
    logic [fetch_pkg::QUEUE_CNT_W-2:0] rd_ptr_q;
    logic [fetch_pkg::QUEUE_CNT_W-1:0] count_q;
    logic                              push_en;
    logic                              pop;

    // a flush also swallows the word arriving with it
    assign push_en = push_i & ~flush_i;
    assign pop     = valid_o & ready_i;

    // room for one more request plus the word already in flight
    assign has_room_o = (count_q <= fetch_pkg::QUEUE_ROOM_LVL);

    // ----------------------------------------
    // output side
    // ----------------------------------------
    assign valid_o       = (count_q != '0);
    assign pc_o          = pc_q[rd_ptr_q];
    assign instr_o       = instr_q[rd_ptr_q];
    assign pred_taken_o  = taken_q[rd_ptr_q];
    assign pred_target_o = target_q[rd_ptr_q];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_en) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // occupancy moves only if exactly one side is active
            if (push_en && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push_en) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_en) begin
            pc_q[wr_ptr_q]     <= pc_i;
            instr_q[wr_ptr_q]  <= instr_i;
            taken_q[wr_ptr_q]  <= pred_taken_i;
            target_q[wr_ptr_q] <= pred_target_i;
        end
    end

endmodule

/* source/pc_gen.sv */
`timescale 1ns/1ps

module pc_gen (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic [fetch_pkg::XLEN-1:0] boot_addr_i,
    input  logic                       has_room_i,
    input  logic                       pred_taken_i,
    input  logic [fetch_pkg::XLEN-1:0] pred_target_i,
    input  logic                       mispredict_i,
    input  logic [fetch_pkg::XLEN-1:0] mispredict_target_i,
    input  logic                       imem_valid_i,
    output logic                       imem_req_o,
    output logic [fetch_pkg::XLEN-1:0] imem_addr_o,
    output logic                       s2_valid_o,
    output logic [fetch_pkg::XLEN-1:0] s2_pc_o
);

    logic [fetch_pkg::XLEN-1:0] npc_d;
    logic [fetch_pkg::XLEN-1:0] npc_q;
    // high for the first cycle out of reset only
    logic                       npc_rst_load_q;
    logic                       s2_live_q;
    logic [fetch_pkg::XLEN-1:0] s2_pc_q;
    logic                       pred_redirect;
    logic                       kill;

    // no request while the boot address is being loaded
    assign imem_req_o  = has_room_i & ~npc_rst_load_q;
    assign imem_addr_o = npc_q;

    // response of a live request, arriving one cycle after it went out
    assign s2_valid_o = s2_live_q & imem_valid_i;
    assign s2_pc_o    = s2_pc_q;

    // a prediction only counts for a word that is really there
    assign pred_redirect = s2_valid_o & pred_taken_i;
    // the request going out now belongs to the wrong path
    assign kill = pred_redirect | mispredict_i;

    // ----------------------------------------
    // next pc select
    // ----------------------------------------
    // later assignments win: hold, sequential, prediction, mispredict
    always_comb begin
        if (npc_rst_load_q) begin
            npc_d = boot_addr_i;
        end else begin
            npc_d = npc_q;
        end
        if (imem_req_o) begin
            npc_d = npc_q + fetch_pkg::INSTR_BYTES;
        end
        if (pred_redirect) begin
            npc_d = pred_target_i;
        end
        if (mispredict_i) begin
            npc_d = mispredict_target_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            npc_rst_load_q <= 1'b1;
            npc_q          <= '0;
            s2_live_q      <= 1'b0;
        end else begin
            npc_rst_load_q <= 1'b0;
            npc_q          <= npc_d;
            s2_live_q      <= imem_req_o & ~kill;
        end
    end

    // address of the word in flight
    always_ff @(posedge clk_i) begin
        if (imem_req_o) begin
            s2_pc_q <= imem_addr_o;
        end
    end

endmodule

/* verilog.f */
source/fetch_pkg.sv
source/branch_predecode.sv
source/bht.sv
source/pc_gen.sv
source/fetch_queue.sv
source/fetch_frontend.sv
sim/fetch_frontend_props.sv
sim/tb_fetch_frontend.sv
